// File: sim.f
+incdir+verilog
verilog/memUnitPkg.sv
verilog/addrGen.sv
verilog/dualPortRam.sv
verilog/memUnit.sv
verilog/configRegs.sv
verilog/memSubsystem.sv
tb/memSubsystemTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module memSubsystemTb \
   -f sim.f -o memSubsystemSim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/memSubsystemSim > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log && exit 0
echo "no result line found in sim.log"
exit 1

// File: tb/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "memUnit_config.svh"

module memSubsystemTb;

   typedef logic [`MEM_ADDR_W-1:0] wordAddr_t;

   logic                   clk;
   logic                   rst;
   logic                   run;
   logic                   done;
   logic                   outValid0;
   memUnitPkg::busReq_t    busReq;
   memUnitPkg::busRsp_t    busRsp;
   logic [`MEM_DATA_W-1:0] in0;
   logic [`MEM_DATA_W-1:0] in1;
   logic [`MEM_DATA_W-1:0] out0;
   logic                   expDone;
   int                     cyc = 0;
   int                     outCount;
   logic [31:0]            lcgState;

   // shadow of the RAM and the port settings as written
   logic [`MEM_DATA_W-1:0] model [0:(1 << `MEM_ADDR_W)-1];
   memUnitPkg::portCfg_t   portCfg [2];

   // expected strobes, keyed by the cycle they are due in
   int                     rspDue [$];
   logic [`MEM_DATA_W-1:0] rspData [$];
   int                     outDue [$];
   logic [`MEM_DATA_W-1:0] outData [$];
   int                     touched [$];

   memSubsystem u_dut (
      .clk       (clk),
      .rst       (rst),
      .busReq    (busReq),
      .busRsp    (busRsp),
      .run       (run),
      .done      (done),
      .in0       (in0),
      .in1       (in1),
      .out0      (out0),
      .outValid0 (outValid0)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic stopWithError(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // address of a port in cycle c after run, -1 when idle
   function automatic int genAddr(input memUnitPkg::portCfg_t p, input int c);
      int        k;
      int        per;
      int        i;
      int        j;
      wordAddr_t a;
      per = int'(p.gen.period);
      k = c - int'(p.gen.delay) - 1;
      if (per == 0 || k < 0 || k >= int'(p.gen.iterations) * per) return -1;
      i = k / per;
      j = k % per;
      if (j >= int'(p.gen.duty)) return -1;
      a = wordAddr_t'(int'(p.gen.start) + i * int'(p.gen.shift) + j * int'(p.gen.incr));
      if (p.reverse) a = {<<{a}};
      return int'(a);
   endfunction

   task automatic issueReq(input logic write, input logic [`BUS_ADDR_W-1:0] addr,
                           input logic [`MEM_DATA_W-1:0] data);
      @(posedge clk);
      #2;
      busReq = '{valid: 1'b1, write: write, addr: addr, wdata: data};
      if (!addr[`MEM_ADDR_W]) begin
         if (write) begin
            model[addr[`MEM_ADDR_W-1:0]] = data;
         end else begin
            rspDue.push_back(cyc + 3);
            rspData.push_back(model[addr[`MEM_ADDR_W-1:0]]);
         end
      end
   endtask

   task automatic idleBus();
      @(posedge clk);
      #2;
      busReq.valid = 1'b0;
   endtask

   task automatic drainExpected();
      int w;
      w = 0;
      while (rspDue.size() > 0 || outDue.size() > 0) begin
         if (w > 20) begin
            stopWithError("expected read strobes never arrived");
         end else begin
            @(posedge clk);
            w++;
         end
      end
   endtask

   task automatic configPort(input int port, input int iterations, input int period,
                             input int duty, input int start, input int shift, input int incr,
                             input int delay, input logic reverse, input logic writeIn);
      logic [`MEM_DATA_W-1:0] vals [8];
      vals[0] = iterations;
      vals[1] = period;
      vals[2] = duty;
      vals[3] = start;
      vals[4] = shift;
      vals[5] = incr;
      vals[6] = delay;
      vals[7] = {30'b0, writeIn, reverse};
      for (int idx = 0; idx < 8; idx++) begin
         issueReq(1'b1, {1'b1, wordAddr_t'(port * 8 + idx)}, vals[idx]);
      end
      idleBus();
      portCfg[port].gen.iterations = vals[0][`MEM_ADDR_W-1:0];
      portCfg[port].gen.period     = vals[1][`MEM_PERIOD_W-1:0];
      portCfg[port].gen.duty       = vals[2][`MEM_PERIOD_W-1:0];
      portCfg[port].gen.start      = vals[3][`MEM_ADDR_W-1:0];
      portCfg[port].gen.shift      = vals[4][`MEM_ADDR_W-1:0];
      portCfg[port].gen.incr       = vals[5][`MEM_ADDR_W-1:0];
      portCfg[port].gen.delay      = vals[6][`MEM_DELAY_W-1:0];
      portCfg[port].reverse        = reverse;
      portCfg[port].writeIn        = writeIn;
   endtask

   // one run strobe, then streams driven per cycle until done
   task automatic runPattern();
      int   lenA;
      int   lenB;
      int   total;
      int   expCount;
      int   c;
      int   a;
      int   b;
      logic finished;
      lenA = int'(portCfg[0].gen.delay)
             + int'(portCfg[0].gen.iterations) * int'(portCfg[0].gen.period);
      lenB = int'(portCfg[1].gen.delay)
             + int'(portCfg[1].gen.iterations) * int'(portCfg[1].gen.period);
      total = ((lenA > lenB) ? lenA : lenB) + 1;
      expCount = portCfg[0].writeIn ? 0 :
                 int'(portCfg[0].gen.iterations) * int'(portCfg[0].gen.duty);
      outCount = 0;
      @(posedge clk);
      #2;
      run = 1'b1;
      c = 0;
      finished = 1'b0;
      while (!finished) begin
         @(posedge clk);
         #2;
         c++;
         run = 1'b0;
         expDone = (c >= total);
         in0 = nextRand();
         in1 = nextRand();
         a = genAddr(portCfg[0], c);
         b = genAddr(portCfg[1], c);
         if (a >= 0 && portCfg[0].writeIn) begin
            model[a] = in0;
            touched.push_back(a);
         end else if (a >= 0) begin
            outDue.push_back(cyc + 3);
            outData.push_back(model[a]);
         end
         if (b >= 0 && portCfg[1].writeIn) begin
            model[b] = in1;
            touched.push_back(b);
         end
         if (c >= total && done) begin
            finished = 1'b1;
         end else if (c > total + 16) begin
            stopWithError("run never finished, done stayed low");
         end
      end
      drainExpected();
      assert (outCount == expCount)
         else stopWithError($sformatf("** Error: outValid0 count = %h, expected %h",
                                      outCount, expCount));
   endtask

   // back-to-back bus reads of every address a run wrote
   task automatic readBack();
      foreach (touched[i]) begin
         issueReq(1'b0, {1'b0, wordAddr_t'(touched[i])}, '0);
      end
      idleBus();
      drainExpected();
      touched.delete();
   endtask

   doneTiming: assert property (@(negedge clk) disable iff (rst) done == expDone)
      else stopWithError($sformatf("** Error: done = %h, expected %h", done, expDone));

   // outputs are settled by the falling edge
   always @(negedge clk) begin
      if (!rst) begin
         if (rspDue.size() > 0 && rspDue[0] == cyc) begin
            assert (busRsp.valid)
               else stopWithError($sformatf("** Error: busRsp.valid = %h, expected %h",
                                            busRsp.valid, 1'b1));
            assert (busRsp.rdata == rspData[0])
               else stopWithError($sformatf("** Error: busRsp.rdata = %h, expected %h",
                                            busRsp.rdata, rspData[0]));
            void'(rspDue.pop_front());
            void'(rspData.pop_front());
         end else begin
            assert (!busRsp.valid)
               else stopWithError($sformatf("** Error: busRsp.valid = %h, expected %h",
                                            busRsp.valid, 1'b0));
         end
         if (outValid0) outCount++;
         if (outDue.size() > 0 && outDue[0] == cyc) begin
            assert (outValid0)
               else stopWithError($sformatf("** Error: outValid0 = %h, expected %h",
                                            outValid0, 1'b1));
            assert (out0 == outData[0])
               else stopWithError($sformatf("** Error: out0 = %h, expected %h",
                                            out0, outData[0]));
            void'(outDue.pop_front());
            void'(outData.pop_front());
         end else begin
            assert (!outValid0)
               else stopWithError($sformatf("** Error: outValid0 = %h, expected %h",
                                            outValid0, 1'b0));
         end
      end
   end

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      run = 1'b0;
      busReq = '0;
      in0 = '0;
      in1 = '0;
      expDone = 1'b1;
      outCount = 0;
      lcgState = 32'd33304;
      repeat (8) @(posedge clk);
      #2;
      rst = 1'b0;

      assert (done && !outValid0 && !busRsp.valid)
         else stopWithError($sformatf(
            "** Error: done/outValid0/busRsp.valid = %h/%h/%h, expected 1/0/0",
            done, outValid0, busRsp.valid));

      // fill every word, then read all of it back with no gaps
      for (int i = 0; i < (1 << `MEM_ADDR_W); i++) begin
         issueReq(1'b1, {1'b0, wordAddr_t'(i)}, nextRand());
      end
      for (int i = 0; i < (1 << `MEM_ADDR_W); i++) begin
         issueReq(1'b0, {1'b0, wordAddr_t'(i)}, '0);
      end
      idleBus();
      drainExpected();

      // port B stores in1
      configPort(0, 0, 0, 0, 0, 0, 0, 0, 1'b0, 1'b0);
      configPort(1, 5, 7, 4, 'h300, 'h11, 3, 3, 1'b0, 1'b1);
      runPattern();
      readBack();

      // port A streams out, B reads longer so it sets done
      configPort(0, 4, 6, 3, 'h20, 'h10, 2, 5, 1'b0, 1'b0);
      configPort(1, 3, 9, 2, 'h80, 'h4, 1, 20, 1'b0, 1'b0);
      runPattern();

      // bit reversal on reads, then on writes
      configPort(1, 0, 0, 0, 0, 0, 0, 0, 1'b0, 1'b0);
      configPort(0, 3, 4, 4, 1, 8, 1, 0, 1'b1, 1'b0);
      runPattern();
      configPort(0, 2, 5, 3, 'h40, 'h20, 5, 2, 1'b1, 1'b1);
      runPattern();
      readBack();

      // zero iterations, with and without a delay
      configPort(0, 0, 0, 0, 0, 0, 0, 4, 1'b0, 1'b0);
      runPattern();
      configPort(0, 0, 0, 0, 0, 0, 0, 0, 1'b0, 1'b0);
      runPattern();

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none
`include "memUnit_config.svh"

module memSubsystem (
   input  wire                       clk,
   input  wire                       rst,
   input  wire memUnitPkg::busReq_t  busReq,
   output wire memUnitPkg::busRsp_t  busRsp,
   input  wire                       run,
   output wire                       done,
   input  wire [`MEM_DATA_W-1:0]     in0,
   input  wire [`MEM_DATA_W-1:0]     in1,
   output wire [`MEM_DATA_W-1:0]     out0,
   output wire                       outValid0
);

   memUnitPkg::busReq_t  cfgReq;
   memUnitPkg::busReq_t  memReq;
   memUnitPkg::portCfg_t cfgA;
   memUnitPkg::portCfg_t cfgB;
   logic                 cfgSel;

   // top address bit selects config space
   assign cfgSel = busReq.addr[`MEM_ADDR_W];

   always_comb begin
      cfgReq       = busReq;
      cfgReq.valid = busReq.valid && cfgSel;
      memReq       = busReq;
      memReq.valid = busReq.valid && !cfgSel;
   end

   configRegs regs (
      .clk    (clk),
      .rst    (rst),
      .busReq (cfgReq),
      .cfgA   (cfgA),
      .cfgB   (cfgB)
   );

   memUnit unit (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .done      (done),
      .busReq    (memReq),
      .busRsp    (busRsp),
      .cfgA      (cfgA),
      .cfgB      (cfgB),
      .in0       (in0),
      .in1       (in1),
      .out0      (out0),
      .outValid0 (outValid0)
   );

endmodule

`default_nettype wire

// File: verilog/configRegs.sv
`timescale 1ns/1ps
`default_nettype none
`include "memUnit_config.svh"

module configRegs (
   input  wire memUnitPkg::busReq_t  busReq,
   input  wire                       clk,
   input  wire                       rst,
   output memUnitPkg::portCfg_t      cfgA,
   output memUnitPkg::portCfg_t      cfgB
);

   logic wrStrobe;
   logic portSel;
   logic [2:0] fieldSel;

   // update one field of a port, value cut to the field width
   function automatic memUnitPkg::portCfg_t setField(
      input memUnitPkg::portCfg_t   cfg,
      input logic [2:0]             sel,
      input logic [`MEM_DATA_W-1:0] data
   );
      memUnitPkg::portCfg_t upd;
      upd = cfg;
      case (sel)
         3'd0: upd.gen.iterations = data[`MEM_ADDR_W-1:0];
         3'd1: upd.gen.period     = data[`MEM_PERIOD_W-1:0];
         3'd2: upd.gen.duty       = data[`MEM_PERIOD_W-1:0];
         3'd3: upd.gen.start      = data[`MEM_ADDR_W-1:0];
         3'd4: upd.gen.shift      = data[`MEM_ADDR_W-1:0];
         3'd5: upd.gen.incr       = data[`MEM_ADDR_W-1:0];
         3'd6: upd.gen.delay      = data[`MEM_DELAY_W-1:0];
         default: begin
            // control word
            upd.reverse = data[0];
            upd.writeIn = data[1];
         end
      endcase
      return upd;
   endfunction

   assign wrStrobe = busReq.valid && busReq.write;

   // index bit 3 picks port B
   assign portSel  = busReq.addr[3];
   assign fieldSel = busReq.addr[2:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfgA <= '0;
         cfgB <= '0;
      end else if (wrStrobe) begin
         if (portSel) begin
            cfgB <= setField(cfgB, fieldSel, busReq.wdata);
         end else begin
            cfgA <= setField(cfgA, fieldSel, busReq.wdata);
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/memUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "memUnit_config.svh"

module memUnit (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        run,
   output logic                       done,
   input  wire memUnitPkg::busReq_t   busReq,
   output memUnitPkg::busRsp_t        busRsp,
   input  wire memUnitPkg::portCfg_t  cfgA,
   input  wire memUnitPkg::portCfg_t  cfgB,
   input  wire [`MEM_DATA_W-1:0]      in0,
   input  wire [`MEM_DATA_W-1:0]      in1,
   output logic [`MEM_DATA_W-1:0]     out0,
   output logic                       outValid0
);

   logic [`MEM_ADDR_W-1:0] genAddrA;
   logic [`MEM_ADDR_W-1:0] genAddrB;
   logic                   genEnA;
   logic                   genEnB;
   logic                   doneA;
   logic                   doneB;
   logic                   busSel;
   logic                   busRead;
   logic                   genRead;
   logic [`MEM_ADDR_W-1:0] addrMuxA;
   logic [`MEM_ADDR_W-1:0] addrMuxB;
   logic [`MEM_DATA_W-1:0] dinMuxA;
   logic                   enMuxA;
   logic                   weMuxA;
   logic                   weMuxB;
   logic [`MEM_ADDR_W-1:0] addrRegA;
   logic [`MEM_ADDR_W-1:0] addrRegB;
   logic [`MEM_DATA_W-1:0] dinRegA;
   logic [`MEM_DATA_W-1:0] dinRegB;
   logic                   enRegA;
   logic                   enRegB;
   logic                   weRegA;
   logic                   weRegB;
   logic [`MEM_DATA_W-1:0] doutA;
   logic [`MEM_DATA_W-1:0] outReg;
   logic [1:0]             busRdPipe;
   logic [1:0]             genRdPipe;
   logic                   rspValid;

   function automatic logic [`MEM_ADDR_W-1:0] reverseBits(input logic [`MEM_ADDR_W-1:0] word);
      logic [`MEM_ADDR_W-1:0] result;
      for (int i = 0; i < `MEM_ADDR_W; i++) begin
         result[i] = word[`MEM_ADDR_W-1-i];
      end
      return result;
   endfunction

   addrGen genA (
      .clk  (clk),
      .rst  (rst),
      .run  (run),
      .cfg  (cfgA.gen),
      .addr (genAddrA),
      .en   (genEnA),
      .done (doneA)
   );

   addrGen genB (
      .clk  (clk),
      .rst  (rst),
      .run  (run),
      .cfg  (cfgB.gen),
      .addr (genAddrB),
      .en   (genEnB),
      .done (doneB)
   );

   assign done = doneA & doneB;

   // bus access takes port A over the generator
   assign busSel  = busReq.valid;
   assign busRead = busReq.valid && !busReq.write;
   assign genRead = genEnA && !cfgA.writeIn && !busSel;

   assign addrMuxA = busSel ? busReq.addr[`MEM_ADDR_W-1:0] :
                     (cfgA.reverse ? reverseBits(genAddrA) : genAddrA);
   assign dinMuxA  = busSel ? busReq.wdata : in0;
   assign enMuxA   = busSel | genEnA;
   assign weMuxA   = busSel ? busReq.write : (genEnA & cfgA.writeIn);

   assign addrMuxB = cfgB.reverse ? reverseBits(genAddrB) : genAddrB;
   assign weMuxB   = genEnB & cfgB.writeIn;

   // input register stage
   always_ff @(posedge clk) begin
      addrRegA <= addrMuxA;
      addrRegB <= addrMuxB;
      dinRegA  <= dinMuxA;
      dinRegB  <= in1;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         enRegA <= 1'b0;
         enRegB <= 1'b0;
         weRegA <= 1'b0;
         weRegB <= 1'b0;
      end else begin
         enRegA <= enMuxA;
         enRegB <= genEnB;
         weRegA <= weMuxA;
         weRegB <= weMuxB;
      end
   end

   dualPortRam ram (
      .clk   (clk),
      .enA   (enRegA),
      .weA   (weRegA),
      .addrA (addrRegA),
      .dinA  (dinRegA),
      .doutA (doutA),
      .enB   (enRegB),
      .weB   (weRegB),
      .addrB (addrRegB),
      .dinB  (dinRegB),
      .doutB ()
   );

   // output register, shared by stream and bus reads
   always_ff @(posedge clk) begin
      outReg <= doutA;
   end

   // strobes ride along the three-cycle read latency
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busRdPipe <= '0;
         genRdPipe <= '0;
         rspValid  <= 1'b0;
         outValid0 <= 1'b0;
      end else begin
         busRdPipe <= {busRdPipe[0], busRead};
         genRdPipe <= {genRdPipe[0], genRead};
         rspValid  <= busRdPipe[1];
         outValid0 <= genRdPipe[1];
      end
   end

   assign out0   = outReg;
   assign busRsp = '{valid: rspValid, rdata: outReg};

endmodule

`default_nettype wire

// File: verilog/dualPortRam.sv
`timescale 1ns/1ps
`default_nettype none
`include "memUnit_config.svh"

module dualPortRam (
   input  wire                    clk,
   input  wire                    enA,
   input  wire                    weA,
   input  wire [`MEM_ADDR_W-1:0]  addrA,
   input  wire [`MEM_DATA_W-1:0]  dinA,
   output logic [`MEM_DATA_W-1:0] doutA,
   input  wire                    enB,
   input  wire                    weB,
   input  wire [`MEM_ADDR_W-1:0]  addrB,
   input  wire [`MEM_DATA_W-1:0]  dinB,
   output logic [`MEM_DATA_W-1:0] doutB
);

   logic [`MEM_DATA_W-1:0] mem [0:(1 << `MEM_ADDR_W)-1];

   // read-before-write on each port, B wins an address clash
   always_ff @(posedge clk) begin
      if (enA) begin
         doutA <= mem[addrA];
         if (weA) begin
            mem[addrA] <= dinA;
         end
      end
      if (enB) begin
         doutB <= mem[addrB];
         if (weB) begin
            mem[addrB] <= dinB;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/addrGen.sv
`timescale 1ns/1ps
`default_nettype none
`include "memUnit_config.svh"

module addrGen (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       run,
   input  wire memUnitPkg::genCfg_t  cfg,
   output logic [`MEM_ADDR_W-1:0]    addr,
   output logic                      en,
   output logic                      done
);

   logic                     busy;
   logic [`MEM_DELAY_W-1:0]  delayCnt;
   logic [`MEM_ADDR_W-1:0]   iterCnt;
   logic [`MEM_PERIOD_W-1:0] perCnt;
   logic [`MEM_ADDR_W-1:0]   baseAddr;
   logic [`MEM_ADDR_W-1:0]   curAddr;
   logic                     noIter;
   logic                     emptyRun;
   logic                     periodEnd;
   logic                     lastStep;
   logic                     active;

   assign noIter    = (cfg.iterations == '0);
   assign emptyRun  = noIter && (cfg.delay == '0);
   assign periodEnd = (perCnt == cfg.period - 1'b1);
   assign lastStep  = periodEnd && (iterCnt == cfg.iterations - 1'b1);

   // past the start delay and inside the outer loop
   assign active = busy && (delayCnt == '0) && !noIter;

   assign en   = active && (perCnt < cfg.duty);
   assign addr = curAddr;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy     <= 1'b0;
         delayCnt <= '0;
         iterCnt  <= '0;
         perCnt   <= '0;
         baseAddr <= '0;
         curAddr  <= '0;
         done     <= 1'b1;
      end else if (run) begin
         // an empty pattern with no delay is finished at once
         busy     <= !emptyRun;
         delayCnt <= cfg.delay;
         iterCnt  <= '0;
         perCnt   <= '0;
         baseAddr <= cfg.start;
         curAddr  <= cfg.start;
         done     <= emptyRun;
      end else if (busy) begin
         if (delayCnt != '0) begin
            delayCnt <= delayCnt - 1'b1;
            // nothing to walk, finish right as the delay expires
            if (delayCnt == 1 && noIter) begin
               busy <= 1'b0;
               done <= 1'b1;
            end
         end else if (noIter || lastStep) begin
            busy <= 1'b0;
            done <= 1'b1;
         end else if (periodEnd) begin
            // next outer step
            perCnt   <= '0;
            iterCnt  <= iterCnt + 1'b1;
            baseAddr <= baseAddr + cfg.shift;
            curAddr  <= baseAddr + cfg.shift;
         end else begin
            perCnt  <= perCnt + 1'b1;
            curAddr <= curAddr + cfg.incr;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/memUnitPkg.sv
`default_nettype none
`include "memUnit_config.svh"

package memUnitPkg;

   // host access, one-cycle strobe on valid
   typedef struct packed {
      logic                   valid;
      logic                   write;
      logic [`BUS_ADDR_W-1:0] addr;
      logic [`MEM_DATA_W-1:0] wdata;
   } busReq_t;

   // read answer, one-cycle strobe
   typedef struct packed {
      logic                   valid;
      logic [`MEM_DATA_W-1:0] rdata;
   } busRsp_t;

   // two-level address pattern
   typedef struct packed {
      logic [`MEM_ADDR_W-1:0]   iterations;
      logic [`MEM_PERIOD_W-1:0] period;
      logic [`MEM_PERIOD_W-1:0] duty;
      logic [`MEM_ADDR_W-1:0]   start;
      logic [`MEM_ADDR_W-1:0]   shift;
      logic [`MEM_ADDR_W-1:0]   incr;
      logic [`MEM_DELAY_W-1:0]  delay;
   } genCfg_t;

   // writeIn set means the port stores its input stream
   typedef struct packed {
      genCfg_t gen;
      logic    reverse;
      logic    writeIn;
   } portCfg_t;

endpackage

`default_nettype wire

// File: verilog/memUnit_config.svh
`ifndef MEM_UNIT_CONFIG_SVH
`define MEM_UNIT_CONFIG_SVH

// data path and word addressing
`define MEM_DATA_W   32
`define MEM_ADDR_W   10

// period and duty counters
`define MEM_PERIOD_W 5

// start delay counter
`define MEM_DELAY_W  10

// top bit picks config space (1) or memory (0)
`define BUS_ADDR_W   (`MEM_ADDR_W + 1)

`endif
